// File: hw/cipher_pkg.sv
package cipher_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Four 32-bit columns form one block
  localparam int unsigned NumLanes = 4;
  localparam int unsigned WordW    = 32;
  localparam int unsigned BlockW   = 128;

  // Key ring holds up to eight words
  localparam int unsigned KeyWords = 8;
  localparam int unsigned KeyW     = 256;

  // Enough for 14 rounds
  localparam int unsigned RndCtrW  = 4;

  ////////////////////
  // Datapath timing
  ////////////////////

  // One byte substituted per cycle
  localparam int unsigned SubCycles    = 4;
  // Rotate stage, then combine stage
  localparam int unsigned KeyExpCycles = 2;

  // Added after the byte rotation
  localparam logic [7:0] SboxXor = 8'h63;

  ////////////////////
  // Types
  ////////////////////

  // Selects rounds (10/12/14) and active key words (4/6/8)
  typedef enum logic [1:0] {
    AES_128,
    AES_192,
    AES_256
  } key_len_e;

  // RSP_RESEEDLESS_NONE is never produced
  typedef enum logic [1:0] {
    RSP_CIPHER,
    RSP_CLEAR,
    RSP_RESEEDLESS_NONE
  } rsp_kind_e;

  // Word i of data and key maps to bits [32*i +: 32]
  typedef struct packed {
    logic [BlockW-1:0] data;
    logic [KeyW-1:0]   key;
    key_len_e          key_len;
    logic              crypt;
    logic              key_clear;
    logic              data_out_clear;
  } cmd_t;

  typedef struct packed {
    logic [BlockW-1:0] data;
    rsp_kind_e         kind;
  } rsp_t;

endpackage

// File: hw/cipher_ctrl_pkg.sv
package cipher_ctrl_pkg;

  // Control FSM states
  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_INIT,
    CTRL_ROUND,
    CTRL_FINISH,
    CTRL_CLEAR_S,
    CTRL_CLEAR_KD,
    CTRL_ERROR
  } ctrl_state_e;

  // Source of the lane state register
  typedef enum logic [1:0] {
    STATE_INIT,
    STATE_ROUND,
    STATE_CLEAR
  } state_sel_e;

  // INIT adds key to state, ROUND to rotated substitution, FINAL to plain substitution
  typedef enum logic [1:0] {
    ADD_RK_INIT,
    ADD_RK_ROUND,
    ADD_RK_FINAL
  } add_rk_sel_e;

  // Source of the key ring
  typedef enum logic [1:0] {
    KEY_INIT,
    KEY_ROUND,
    KEY_CLEAR
  } key_sel_e;

  // Shared by all lanes
  typedef struct packed {
    state_sel_e  state_sel;
    add_rk_sel_e add_rk_sel;
    logic        state_we;
    logic        sub_en;
  } lane_ctrl_t;

endpackage

// File: hw/cipher_control_fsm.sv
`timescale 1ns/1ns

module cipher_control_fsm (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  // Command handshake
  input  logic                               cmd_valid_i,
  input  cipher_pkg::cmd_t                   cmd_i,
  output logic                               cmd_ready_o,

  // Lane control
  output cipher_ctrl_pkg::lane_ctrl_t        lane_ctrl_o,
  input  logic                               sub_req_i,
  output logic                               sub_ack_o,

  // Key expansion control
  output cipher_ctrl_pkg::key_sel_e          key_sel_o,
  output logic                               key_we_o,
  output logic                               key_exp_en_o,
  input  logic                               key_exp_req_i,
  output logic                               key_exp_ack_o,
  output logic [cipher_pkg::RndCtrW-1:0]     rnd_ctr_o,

  // Output register control
  output logic                               out_load_o,
  output logic                               out_clear_o,
  output cipher_pkg::rsp_kind_e              rsp_kind_o,
  input  logic                               out_busy_i,

  output logic                               alert_o
);

  cipher_ctrl_pkg::ctrl_state_e      state_d, state_q;
  logic [cipher_pkg::RndCtrW-1:0]    rnd_ctr_d, rnd_ctr_q;
  logic [cipher_pkg::RndCtrW-1:0]    num_rounds_d, num_rounds_q;
  logic                              key_clear_d, key_clear_q;
  logic                              loaded_d, loaded_q;
  logic                              ready_q;
  logic                              advance;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    // Defaults, nothing written
    lane_ctrl_o = '{state_sel:  cipher_ctrl_pkg::STATE_ROUND,
                    add_rk_sel: cipher_ctrl_pkg::ADD_RK_ROUND,
                    state_we:   1'b0,
                    sub_en:     1'b0};
    sub_ack_o     = 1'b0;
    key_sel_o     = cipher_ctrl_pkg::KEY_ROUND;
    key_we_o      = 1'b0;
    key_exp_en_o  = 1'b0;
    key_exp_ack_o = 1'b0;
    out_load_o    = 1'b0;
    out_clear_o   = 1'b0;
    rsp_kind_o    = cipher_pkg::RSP_CIPHER;
    alert_o       = 1'b0;
    advance       = 1'b0;

    state_d      = state_q;
    rnd_ctr_d    = rnd_ctr_q;
    num_rounds_d = num_rounds_q;
    key_clear_d  = key_clear_q;
    loaded_d     = loaded_q;

    unique case (state_q)
      cipher_ctrl_pkg::CTRL_IDLE: begin
        if (cmd_valid_i && ready_q) begin
          key_clear_d = cmd_i.key_clear;
          if (cmd_i.key_clear || cmd_i.data_out_clear) begin
            if (cmd_i.data_out_clear) begin
              // State must be wiped before the output
              state_d = cipher_ctrl_pkg::CTRL_CLEAR_S;
            end else begin
              // Key clear only, respond right away
              out_load_o  = 1'b1;
              out_clear_o = 1'b1;
              rsp_kind_o  = cipher_pkg::RSP_CLEAR;
              state_d     = cipher_ctrl_pkg::CTRL_CLEAR_KD;
            end
          end else if (cmd_i.crypt) begin
            // Load input block and full key
            lane_ctrl_o.state_sel = cipher_ctrl_pkg::STATE_INIT;
            lane_ctrl_o.state_we  = 1'b1;
            key_sel_o             = cipher_ctrl_pkg::KEY_INIT;
            key_we_o              = 1'b1;
            unique case (cmd_i.key_len)
              cipher_pkg::AES_128: num_rounds_d = 4'd10;
              cipher_pkg::AES_192: num_rounds_d = 4'd12;
              default:             num_rounds_d = 4'd14;
            endcase
            rnd_ctr_d = '0;
            state_d   = cipher_ctrl_pkg::CTRL_INIT;
          end else begin
            // Accepted but nothing requested
            state_d = cipher_ctrl_pkg::CTRL_ERROR;
          end
        end
      end

      cipher_ctrl_pkg::CTRL_INIT: begin
        // Initial key addition with rk0, first key step starts
        lane_ctrl_o.add_rk_sel = cipher_ctrl_pkg::ADD_RK_INIT;
        lane_ctrl_o.state_we   = 1'b1;
        key_exp_en_o           = 1'b1;
        rnd_ctr_d              = rnd_ctr_q + 1'b1;
        state_d                = cipher_ctrl_pkg::CTRL_ROUND;
      end

      cipher_ctrl_pkg::CTRL_ROUND: begin
        // Advance only once both units are done
        lane_ctrl_o.sub_en = 1'b1;
        key_exp_en_o       = 1'b1;
        advance            = sub_req_i & key_exp_req_i;
        if (advance) begin
          lane_ctrl_o.state_we = 1'b1;
          sub_ack_o            = 1'b1;
          key_exp_ack_o        = 1'b1;
          key_we_o             = 1'b1;
          rnd_ctr_d            = rnd_ctr_q + 1'b1;
          // Last regular round
          if (rnd_ctr_q >= num_rounds_q - 1'b1) begin
            loaded_d = 1'b0;
            state_d  = cipher_ctrl_pkg::CTRL_FINISH;
          end
        end
      end

      cipher_ctrl_pkg::CTRL_FINISH: begin
        if (!loaded_q) begin
          // Final round skips rotation, result goes straight to output
          lane_ctrl_o.add_rk_sel = cipher_ctrl_pkg::ADD_RK_FINAL;
          lane_ctrl_o.state_sel  = cipher_ctrl_pkg::STATE_CLEAR;
          lane_ctrl_o.sub_en     = 1'b1;
          key_exp_en_o           = 1'b1;
          advance                = sub_req_i & key_exp_req_i;
          if (advance) begin
            // State wiped as the result is captured
            lane_ctrl_o.state_we = 1'b1;
            sub_ack_o            = 1'b1;
            key_exp_ack_o        = 1'b1;
            out_load_o           = 1'b1;
            loaded_d             = 1'b1;
          end
        end else if (!out_busy_i) begin
          loaded_d = 1'b0;
          state_d  = cipher_ctrl_pkg::CTRL_IDLE;
        end
      end

      cipher_ctrl_pkg::CTRL_CLEAR_S: begin
        lane_ctrl_o.state_sel = cipher_ctrl_pkg::STATE_CLEAR;
        lane_ctrl_o.state_we  = 1'b1;
        out_load_o            = 1'b1;
        out_clear_o           = 1'b1;
        rsp_kind_o            = cipher_pkg::RSP_CLEAR;
        state_d               = cipher_ctrl_pkg::CTRL_CLEAR_KD;
      end

      cipher_ctrl_pkg::CTRL_CLEAR_KD: begin
        // Response already loaded here
        if (key_clear_q) begin
          key_sel_o = cipher_ctrl_pkg::KEY_CLEAR;
          key_we_o  = 1'b1;
        end
        if (!out_busy_i) begin
          state_d = cipher_ctrl_pkg::CTRL_IDLE;
        end
      end

      cipher_ctrl_pkg::CTRL_ERROR: begin
        // Terminal, left only by reset
        alert_o = 1'b1;
      end

      default: begin
        alert_o = 1'b1;
        state_d = cipher_ctrl_pkg::CTRL_ERROR;
      end
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= cipher_ctrl_pkg::CTRL_IDLE;
      rnd_ctr_q    <= '0;
      num_rounds_q <= '0;
      key_clear_q  <= 1'b0;
      loaded_q     <= 1'b0;
      ready_q      <= 1'b0;
    end else begin
      state_q      <= state_d;
      rnd_ctr_q    <= rnd_ctr_d;
      num_rounds_q <= num_rounds_d;
      key_clear_q  <= key_clear_d;
      loaded_q     <= loaded_d;
      // Low in reset, then follows IDLE
      ready_q      <= (state_d == cipher_ctrl_pkg::CTRL_IDLE);
    end
  end

  assign cmd_ready_o = ready_q;
  assign rnd_ctr_o   = rnd_ctr_q;

endmodule

// File: hw/key_expand.sv
`timescale 1ns/1ns

module key_expand (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic [cipher_pkg::KeyW-1:0]                         key_i,
  input  cipher_pkg::key_len_e                                key_len_i,
  input  cipher_ctrl_pkg::key_sel_e                           key_sel_i,
  input  logic                                                key_we_i,
  input  logic                                                key_exp_en_i,
  input  logic                                                key_exp_ack_i,
  input  logic [cipher_pkg::RndCtrW-1:0]                      rnd_ctr_i,
  output logic                                                key_exp_req_o,
  output logic [cipher_pkg::NumLanes-1:0][cipher_pkg::WordW-1:0] round_key_o
);

  logic [cipher_pkg::KeyWords-1:0][cipher_pkg::WordW-1:0] ring_q, ring_step;
  logic [$clog2(cipher_pkg::KeyWords)-1:0]                last_idx;
  logic [$clog2(cipher_pkg::KeyExpCycles+1)-1:0]          ctr_q;
  logic [cipher_pkg::WordW-1:0]                           rot_q, new_q;
  cipher_pkg::key_len_e                                   key_len_q;

  // Last active ring word
  always_comb begin
    unique case (key_len_q)
      cipher_pkg::AES_128: last_idx = 3'd3;
      cipher_pkg::AES_192: last_idx = 3'd5;
      default:             last_idx = 3'd7;
    endcase
  end

  // Shift active words down, new word at the top
  always_comb begin
    ring_step = ring_q;
    for (int i = 0; i < cipher_pkg::KeyWords - 1; i++) begin
      if (i < last_idx) begin
        ring_step[i] = ring_q[i+1];
      end
    end
    ring_step[last_idx] = new_q;
  end

  assign key_exp_req_o = (ctr_q == cipher_pkg::KeyExpCycles);

  // Step counter, restarts on load or ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q     <= '0;
      key_len_q <= cipher_pkg::AES_128;
    end else begin
      if (key_we_i && key_sel_i == cipher_ctrl_pkg::KEY_INIT) begin
        key_len_q <= key_len_i;
        ctr_q     <= '0;
      end else if (key_exp_ack_i) begin
        ctr_q <= '0;
      end else if (key_exp_en_i && !key_exp_req_o) begin
        ctr_q <= ctr_q + 1'b1;
      end
    end
  end

  // Two-stage new word: rotate, then combine with word 0 and round index
  always_ff @(posedge clk_i) begin
    if (key_exp_en_i && !key_exp_req_o) begin
      if (ctr_q == '0) begin
        rot_q <= {ring_q[last_idx][cipher_pkg::WordW-9:0],
                  ring_q[last_idx][cipher_pkg::WordW-1 -: 8]};
      end else begin
        new_q <= ring_q[0] ^ rot_q ^ cipher_pkg::WordW'(rnd_ctr_i);
      end
    end
  end

  // Key ring
  always_ff @(posedge clk_i) begin
    if (key_we_i) begin
      unique case (key_sel_i)
        cipher_ctrl_pkg::KEY_INIT:  ring_q <= key_i;
        cipher_ctrl_pkg::KEY_ROUND: ring_q <= ring_step;
        default:                    ring_q <= '0;
      endcase
    end
  end

  // rk0 during the initial addition, the stepped ring in every round
  assign round_key_o = (rnd_ctr_i == '0) ? ring_q[cipher_pkg::NumLanes-1:0] :
                                           ring_step[cipher_pkg::NumLanes-1:0];

endmodule

// File: hw/cipher_lane.sv
`timescale 1ns/1ns

module cipher_lane (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  cipher_ctrl_pkg::lane_ctrl_t  ctrl_i,
  input  logic [cipher_pkg::WordW-1:0] data_word_i,
  input  logic [cipher_pkg::WordW-1:0] round_key_i,
  input  logic                         sub_ack_i,
  output logic                         sub_req_o,
  output logic [cipher_pkg::WordW-1:0] state_o
);

  logic [$clog2(cipher_pkg::SubCycles+1)-1:0] sub_ctr_q;
  logic [1:0]                                 sub_byte;
  logic [7:0]                                 byte_in;
  logic [cipher_pkg::WordW-1:0]               state_q, state_d, sub_q, result;

  ////////////////////
  // Substitution
  ////////////////////

  // Byte index, lowest byte first
  assign sub_byte  = sub_ctr_q[1:0];
  assign byte_in   = state_q[{sub_byte, 3'b000} +: 8];
  assign sub_req_o = (sub_ctr_q == cipher_pkg::SubCycles);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sub_ctr_q <= '0;
    end else if (sub_ack_i) begin
      sub_ctr_q <= '0;
    end else if (ctrl_i.sub_en && !sub_req_o) begin
      sub_ctr_q <= sub_ctr_q + 1'b1;
    end
  end

  // Rotate left by one, then add constant
  always_ff @(posedge clk_i) begin
    if (ctrl_i.sub_en && !sub_req_o) begin
      sub_q[{sub_byte, 3'b000} +: 8] <= {byte_in[6:0], byte_in[7]} ^ cipher_pkg::SboxXor;
    end
  end

  ////////////////////
  // Key addition
  ////////////////////

  always_comb begin
    unique case (ctrl_i.add_rk_sel)
      cipher_ctrl_pkg::ADD_RK_ROUND: begin
        // Mixing is a byte rotation of the word
        result = {sub_q[cipher_pkg::WordW-9:0], sub_q[cipher_pkg::WordW-1 -: 8]} ^ round_key_i;
      end
      cipher_ctrl_pkg::ADD_RK_FINAL: result = sub_q ^ round_key_i;
      default:                       result = state_q ^ round_key_i;
    endcase
  end

  always_comb begin
    unique case (ctrl_i.state_sel)
      cipher_ctrl_pkg::STATE_INIT:  state_d = data_word_i;
      cipher_ctrl_pkg::STATE_ROUND: state_d = result;
      default:                      state_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_i.state_we) begin
      state_q <= state_d;
    end
  end

  // Output register takes the final round result directly
  assign state_o = result;

endmodule

// File: hw/data_out_reg.sv
`timescale 1ns/1ns

module data_out_reg (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [cipher_pkg::BlockW-1:0] lanes_i,
  input  logic                          out_load_i,
  input  logic                          out_clear_i,
  input  cipher_pkg::rsp_kind_e         rsp_kind_i,
  input  logic                          rsp_ready_i,
  output logic                          rsp_valid_o,
  output cipher_pkg::rsp_t              rsp_o,
  output logic                          out_busy_o
);

  cipher_pkg::rsp_t rsp_q;
  logic             valid_q;

  // Valid stays up until the transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (out_load_i) begin
      valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Held while waiting on the consumer
  always_ff @(posedge clk_i) begin
    if (out_load_i) begin
      rsp_q.data <= out_clear_i ? '0 : lanes_i;
      rsp_q.kind <= rsp_kind_i;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_o       = rsp_q;
  // Low on the transfer cycle
  assign out_busy_o  = valid_q & ~rsp_ready_i;

endmodule

// File: hw/cipher_core.sv
`timescale 1ns/1ns

module cipher_core (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             cmd_valid_i,
  input  cipher_pkg::cmd_t cmd_i,
  output logic             cmd_ready_o,
  output logic             rsp_valid_o,
  output cipher_pkg::rsp_t rsp_o,
  input  logic             rsp_ready_i,
  output logic             alert_o
);

  cipher_ctrl_pkg::lane_ctrl_t                                   lane_ctrl;
  cipher_ctrl_pkg::key_sel_e                                     key_sel;
  cipher_pkg::rsp_kind_e                                         rsp_kind;
  logic [cipher_pkg::NumLanes-1:0]                               sub_req;
  logic [cipher_pkg::NumLanes-1:0][cipher_pkg::WordW-1:0]        round_key;
  logic [cipher_pkg::BlockW-1:0]                                 lane_state;
  logic [cipher_pkg::RndCtrW-1:0]                                rnd_ctr;
  logic sub_ack, key_we, key_exp_en, key_exp_req, key_exp_ack;
  logic out_load, out_clear, out_busy;

  cipher_control_fsm u_fsm (
    .clk_i, .rst_ni,
    .cmd_valid_i, .cmd_i, .cmd_ready_o,
    .lane_ctrl_o   (lane_ctrl),
    // All lanes finish together, AND for robustness
    .sub_req_i     (&sub_req),
    .sub_ack_o     (sub_ack),
    .key_sel_o     (key_sel),
    .key_we_o      (key_we),
    .key_exp_en_o  (key_exp_en),
    .key_exp_req_i (key_exp_req),
    .key_exp_ack_o (key_exp_ack),
    .rnd_ctr_o     (rnd_ctr),
    .out_load_o    (out_load),
    .out_clear_o   (out_clear),
    .rsp_kind_o    (rsp_kind),
    .out_busy_i    (out_busy),
    .alert_o
  );

  key_expand u_key_expand (
    .clk_i, .rst_ni,
    .key_i         (cmd_i.key),
    .key_len_i     (cmd_i.key_len),
    .key_sel_i     (key_sel),
    .key_we_i      (key_we),
    .key_exp_en_i  (key_exp_en),
    .key_exp_ack_i (key_exp_ack),
    .rnd_ctr_i     (rnd_ctr),
    .key_exp_req_o (key_exp_req),
    .round_key_o   (round_key)
  );

  // One lane per state column
  for (genvar i = 0; i < cipher_pkg::NumLanes; i++) begin : gen_lanes
    cipher_lane u_lane (
      .clk_i, .rst_ni,
      .ctrl_i      (lane_ctrl),
      .data_word_i (cmd_i.data[i*cipher_pkg::WordW +: cipher_pkg::WordW]),
      .round_key_i (round_key[i]),
      .sub_ack_i   (sub_ack),
      .sub_req_o   (sub_req[i]),
      .state_o     (lane_state[i*cipher_pkg::WordW +: cipher_pkg::WordW])
    );
  end

  data_out_reg u_data_out (
    .clk_i, .rst_ni,
    .lanes_i     (lane_state),
    .out_load_i  (out_load),
    .out_clear_i (out_clear),
    .rsp_kind_i  (rsp_kind),
    .rsp_ready_i,
    .rsp_valid_o,
    .rsp_o,
    .out_busy_o  (out_busy)
  );

endmodule

// File: dv/cipher_core_assertions.sv
`timescale 1ns/1ns

module cipher_core_assertions (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             cmd_ready_o,
  input logic             rsp_valid_o,
  input logic             rsp_ready_i,
  input cipher_pkg::rsp_t rsp_o,
  input logic             alert_o
);

  // Stalled response keeps valid and data
  rsp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else $error("Response changed while stalled");

  // No commands once the alert is up
  alert_blocks_cmd_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |-> !cmd_ready_o)
    else $error("Command ready while alert is set");

  // Alert is left only by reset
  alert_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |=> alert_o)
    else $error("Alert dropped without reset");

  // Idle core holds no response
  no_rsp_when_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_ready_o |-> !rsp_valid_o)
    else $error("Response valid while command ready");

endmodule

bind cipher_core cipher_core_assertions u_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .cmd_ready_o (cmd_ready_o),
  .rsp_valid_o (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_o       (rsp_o),
  .alert_o     (alert_o)
);

// File: dv/tb_cipher_core.sv
`timescale 1ns/1ns

module tb_cipher_core;

  localparam int unsigned ClkPeriod     = 20;
  localparam int unsigned Seed          = 98;
  localparam int unsigned NumRandom     = 18;
  // Random ciphers, three clear/cipher pairs, one error command
  localparam int unsigned NumCmds       = NumRandom + 6 + 1;
  // Error command gets no response
  localparam int unsigned NumRsp        = NumCmds - 1;
  localparam int unsigned TimeoutCycles = 100 * NumCmds;

  logic             clk_i;
  logic             rst_ni;
  logic             cmd_valid_i;
  cipher_pkg::cmd_t cmd_i;
  logic             cmd_ready_o;
  logic             rsp_valid_o;
  cipher_pkg::rsp_t rsp_o;
  logic             rsp_ready_i;
  logic             alert_o;

  // Responses seen by the monitor in arrival order
  cipher_pkg::rsp_t rsp_q[$];
  cipher_pkg::rsp_t held_rsp;
  logic             rsp_held  = 1'b0;
  int unsigned      rsp_count = 0;

  cipher_core dut (
    .clk_i,
    .rst_ni,
    .cmd_valid_i,
    .cmd_i,
    .cmd_ready_o,
    .rsp_valid_o,
    .rsp_o,
    .rsp_ready_i,
    .alert_o
  );

  ////////////////////
  // Reporting
  ////////////////////

  task automatic report_failure();
    $display("Test failures found");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [255:0] act,
                             input logic [255:0] exp);
    if (act !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, act, exp);
      report_failure();
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [31:0] rotl8(input logic [31:0] w);
    return {w[23:0], w[31:24]};
  endfunction

  // Each byte rotated left by one and XORed with the constant
  function automatic logic [31:0] sub_word(input logic [31:0] w);
    logic [31:0] s;
    logic [7:0]  b;
    for (int k = 0; k < 4; k++) begin
      b = w[8*k +: 8];
      s[8*k +: 8] = {b[6:0], b[7]} ^ cipher_pkg::SboxXor;
    end
    return s;
  endfunction

  function automatic logic [127:0] model_cipher(input cipher_pkg::cmd_t c);
    logic [31:0]  ring [8];
    logic [31:0]  st [4];
    logic [31:0]  new_word;
    logic [127:0] result;
    int           n;
    int           nr;
    case (c.key_len)
      cipher_pkg::AES_128: begin
        n  = 4;
        nr = 10;
      end
      cipher_pkg::AES_192: begin
        n  = 6;
        nr = 12;
      end
      default: begin
        n  = 8;
        nr = 14;
      end
    endcase
    for (int i = 0; i < 8; i++) begin
      ring[i] = c.key[32*i +: 32];
    end
    // Initial key addition with rk0
    for (int i = 0; i < 4; i++) begin
      st[i] = c.data[32*i +: 32] ^ ring[i];
    end
    for (int r = 1; r <= nr; r++) begin
      // Ring advances once per round
      new_word = ring[0] ^ rotl8(ring[n-1]) ^ 32'(r);
      for (int i = 0; i < n - 1; i++) begin
        ring[i] = ring[i+1];
      end
      ring[n-1] = new_word;
      for (int i = 0; i < 4; i++) begin
        // Final round has no rotation
        if (r < nr) begin
          st[i] = rotl8(sub_word(st[i])) ^ ring[i];
        end else begin
          st[i] = sub_word(st[i]) ^ ring[i];
        end
      end
    end
    for (int i = 0; i < 4; i++) begin
      result[32*i +: 32] = st[i];
    end
    return result;
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic cipher_pkg::cmd_t random_cipher_cmd(input cipher_pkg::key_len_e kl);
    cipher_pkg::cmd_t c;
    c = '0;
    for (int i = 0; i < 4; i++) begin
      c.data[32*i +: 32] = $urandom();
    end
    for (int i = 0; i < 8; i++) begin
      c.key[32*i +: 32] = $urandom();
    end
    c.key_len = kl;
    c.crypt   = 1'b1;
    return c;
  endfunction

  // Returns on the edge where the command transfers
  task automatic send_cmd(input cipher_pkg::cmd_t c);
    check_value("pending responses", rsp_q.size(), 0);
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_i       <= c;
    rsp_ready_i <= 1'b0;
    @(negedge clk_i);
    while (!cmd_ready_o) begin
      @(negedge clk_i);
    end
    // No alert before the error command
    check_value("alert_o", alert_o, 1'b0);
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
  endtask

  // Random back-pressure until the monitor sees one transfer
  task automatic wait_rsp(output cipher_pkg::rsp_t r);
    while (rsp_q.size() == 0) begin
      @(posedge clk_i);
      rsp_ready_i <= ($urandom_range(0, 2) == 0);
    end
    r = rsp_q.pop_front();
  endtask

  task automatic run_cipher(input cipher_pkg::cmd_t c);
    cipher_pkg::rsp_t r;
    logic [127:0]     exp;
    exp = model_cipher(c);
    send_cmd(c);
    wait_rsp(r);
    check_value("rsp_o.data", r.data, exp);
    check_value("rsp_o.kind", r.kind, cipher_pkg::RSP_CIPHER);
  endtask

  task automatic run_clear(input logic key_clr, input logic out_clr,
                           input int unsigned latency);
    cipher_pkg::cmd_t c;
    cipher_pkg::rsp_t r;
    int unsigned      lat;
    c                = random_cipher_cmd(cipher_pkg::AES_256);
    c.crypt          = 1'b0;
    c.key_clear      = key_clr;
    c.data_out_clear = out_clr;
    send_cmd(c);
    // Ready stays low here so valid is counted from acceptance
    lat = 0;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!rsp_valid_o && lat < 8);
    check_value("rsp latency", lat, latency);
    wait_rsp(r);
    check_value("rsp_o.data", r.data, '0);
    check_value("rsp_o.kind", r.kind, cipher_pkg::RSP_CLEAR);
  endtask

  // Command that requests nothing
  task automatic run_error();
    cipher_pkg::cmd_t c;
    c       = random_cipher_cmd(cipher_pkg::AES_128);
    c.crypt = 1'b0;
    send_cmd(c);
    repeat (20) begin
      @(posedge clk_i);
      rsp_ready_i <= 1'b1;
      @(negedge clk_i);
      check_value("alert_o", alert_o, 1'b1);
      check_value("cmd_ready_o", cmd_ready_o, 1'b0);
      check_value("rsp_valid_o", rsp_valid_o, 1'b0);
    end
    check_value("pending responses", rsp_q.size(), 0);
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      rsp_held = 1'b0;
    end else begin
      if (rsp_held) begin
        // Stalled response keeps valid and data
        check_value("rsp_valid_o", rsp_valid_o, 1'b1);
        check_value("rsp_o", rsp_o, held_rsp);
      end
      // Transfer on the coming edge
      if (rsp_valid_o && rsp_ready_i) begin
        rsp_q.push_back(rsp_o);
        rsp_count++;
      end
      rsp_held = rsp_valid_o && !rsp_ready_i;
      held_rsp = rsp_o;
    end
  end

  ////////////////////
  // Clock, watchdog, main
  ////////////////////

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("Timeout, the run did not finish within %0d clock cycles", TimeoutCycles);
    report_failure();
  end

  initial begin
    void'($urandom(Seed));
    rst_ni      <= 1'b0;
    cmd_valid_i <= 1'b0;
    cmd_i       <= '0;
    rsp_ready_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    // Outputs quiet while in reset
    check_value("cmd_ready_o", cmd_ready_o, 1'b0);
    check_value("rsp_valid_o", rsp_valid_o, 1'b0);
    check_value("alert_o", alert_o, 1'b0);
    @(posedge clk_i);
    rst_ni <= 1'b1;

    // All three key lengths in turn
    for (int i = 0; i < NumRandom; i++) begin
      run_cipher(random_cipher_cmd(cipher_pkg::key_len_e'(i % 3)));
    end

    // Each clear is followed by a cipher with a fresh key
    run_clear(1'b0, 1'b1, 2);
    run_cipher(random_cipher_cmd(cipher_pkg::AES_256));
    run_clear(1'b1, 1'b0, 1);
    run_cipher(random_cipher_cmd(cipher_pkg::AES_128));
    run_clear(1'b1, 1'b1, 2);
    run_cipher(random_cipher_cmd(cipher_pkg::AES_192));

    // Terminal state so it runs last
    run_error();

    check_value("response count", rsp_count, NumRsp);
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: tb.f
hw/cipher_pkg.sv
hw/cipher_ctrl_pkg.sv
hw/cipher_control_fsm.sv
hw/key_expand.sv
hw/cipher_lane.sv
hw/data_out_reg.sv
hw/cipher_core.sv
dv/cipher_core_assertions.sv
dv/tb_cipher_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_cipher_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "All tests passed!" $(LOG); then \
		echo "Simulation FAILED, no result in log"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
